//--- src/decode_settings.svh
// macros: lane count, data width and register address width of the decode subsystem
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// number of decode lanes, 4 also works
`define NUM_LANES 2

// data width of operands and instruction words
`define XLEN 32

// register address width, 32 registers
`define REG_AW 5

`endif

//--- src/rv_isa_pkg.sv
// package rv_isa_pkg: RV32I major opcodes and the instruction format union
package rv_isa_pkg;

	//////////////////////////////
	// major opcodes, instr[6:0]
	//////////////////////////////
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	//////////////////////////////
	// one word, six formats
	//////////////////////////////
	typedef union packed {
		struct packed {
			logic [6:0] funct7;   // bit 30 selects sub/sra
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm_11_0;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm_31_12;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} rv_instr_u;

endpackage

//--- src/decode_pkg.sv
// package decode_pkg: operation-type codes and sub-op field layout of the decoded result
package decode_pkg;

	localparam int OPT_W = 5;   // width of op_type

	//////////////////////////////
	// operation types
	//////////////////////////////
	localparam logic [OPT_W-1:0] OPT_ALU_RR  = 5'd0;
	localparam logic [OPT_W-1:0] OPT_ALU_RI  = 5'd1;
	localparam logic [OPT_W-1:0] OPT_LOAD    = 5'd2;
	localparam logic [OPT_W-1:0] OPT_STORE   = 5'd3;
	localparam logic [OPT_W-1:0] OPT_BRANCH  = 5'd4;
	localparam logic [OPT_W-1:0] OPT_LUI     = 5'd5;
	localparam logic [OPT_W-1:0] OPT_AUIPC   = 5'd6;
	localparam logic [OPT_W-1:0] OPT_JAL     = 5'd7;
	localparam logic [OPT_W-1:0] OPT_JALR    = 5'd8;
	localparam logic [OPT_W-1:0] OPT_ILLEGAL = 5'd31;

	//////////////////////////////
	// sub-op layout in op_c
	//////////////////////////////
	// alu and load ops only
	localparam int SUBOP_F3_LSB  = 0;   // funct3
	localparam int SUBOP_F3_MSB  = 2;
	localparam int SUBOP_ALT_BIT = 3;   // copy of instr[30]

endpackage

//--- src/decode_lane_if.sv
// interfaces lane_in_if, lane_out_if and rf_read_if with their modports
`timescale 1ns/1ns
`include "decode_settings.svh"

// fetch word from the dispatcher into one lane
interface lane_in_if;
	logic             valid;
	logic             ready;
	logic [`XLEN-1:0] instr;

	modport dispatch (output valid, output instr, input ready);
	modport lane     (input valid, input instr, output ready);
endinterface

// decoded result from one lane to the collector
interface lane_out_if import decode_pkg::*; ();
	logic               valid;
	logic               ready;
	logic [`XLEN-1:0]   op_a;
	logic [`XLEN-1:0]   op_b;
	logic [`XLEN-1:0]   op_c;
	logic [`REG_AW-1:0] rd;
	logic [OPT_W-1:0]   op_type;

	modport lane      (output valid, output op_a, output op_b, output op_c,
		output rd, output op_type, input ready);
	modport collector (input valid, input op_a, input op_b, input op_c,
		input rd, input op_type, output ready);
endinterface

// two read ports, data one clock after address
interface rf_read_if;
	logic [`REG_AW-1:0] ra_addr;
	logic [`REG_AW-1:0] rb_addr;
	logic [`XLEN-1:0]   ra_data;
	logic [`XLEN-1:0]   rb_data;

	modport lane    (output ra_addr, output rb_addr, input ra_data, input rb_data);
	modport regfile (input ra_addr, input rb_addr, output ra_data, output rb_data);
endinterface

//--- src/instr_dispatch.sv
// module instr_dispatch: round-robin steering of the fetch stream onto the decode lanes
`timescale 1ns/1ns
`include "decode_settings.svh"

module instr_dispatch (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             fetch_valid,
	output logic             fetch_ready,
	input  logic [`XLEN-1:0] instr,
	lane_in_if.dispatch      lanes [`NUM_LANES]
);

	localparam int PW = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;
	localparam logic [PW-1:0] LAST = PW'(`NUM_LANES - 1);

	logic [PW-1:0]         turn;         // lane that gets the next fetch word
	logic [`NUM_LANES-1:0] lane_ready;

	//////////////////////////////
	// per-lane steering
	//////////////////////////////
	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
		localparam logic [PW-1:0] IDX = PW'(g);

		assign lanes[g].valid = fetch_valid && (turn == IDX);
		assign lanes[g].instr = (turn == IDX) ? instr : '0;   // others see zero
		assign lane_ready[g]  = lanes[g].ready;
	end

	// only the lane in turn may stall fetch
	assign fetch_ready = lane_ready[turn];

	//////////////////////////////
	// turn pointer
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			turn <= '0;
		end else if (fetch_valid && fetch_ready) begin
			// move on after every accepted word
			if (turn == LAST) begin
				turn <= '0;
			end else begin
				turn <= turn + 1'b1;
			end
		end
	end

endmodule

//--- src/decode_lane.sv
// module decode_lane: one instruction slot with format decode, operand read and result register
`timescale 1ns/1ns
`include "decode_settings.svh"

module decode_lane import rv_isa_pkg::*, decode_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	lane_in_if.lane   in,
	lane_out_if.lane  out,
	rf_read_if.lane   rf
);

	// slot states, one step per clock after accept
	localparam logic [1:0] S_IDLE = 2'd0;   // empty, ready for a word
	localparam logic [1:0] S_ADDR = 2'd1;   // read addresses out to regfile
	localparam logic [1:0] S_DATA = 2'd2;   // read data back, capture next edge
	localparam logic [1:0] S_FULL = 2'd3;   // result held for the collector

	logic [1:0]         state;
	rv_instr_u          ir;          // stored instruction
	logic [`XLEN-1:0]   imm_i;
	logic [`XLEN-1:0]   imm_s;
	logic [`XLEN-1:0]   imm_b;
	logic [`XLEN-1:0]   imm_u;
	logic [`XLEN-1:0]   imm_j;
	logic [`XLEN-1:0]   sub_op;
	logic [`XLEN-1:0]   nxt_a;
	logic [`XLEN-1:0]   nxt_b;
	logic [`XLEN-1:0]   nxt_c;
	logic [`REG_AW-1:0] nxt_rd;
	logic [OPT_W-1:0]   nxt_type;

	//////////////////////////////
	// slot control
	//////////////////////////////
	assign in.ready  = (state == S_IDLE);
	assign out.valid = (state == S_FULL);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:  state <= in.valid ? S_ADDR : S_IDLE;
				S_ADDR:  state <= S_DATA;
				S_DATA:  state <= S_FULL;
				S_FULL:  state <= out.ready ? S_IDLE : S_FULL;   // hold until taken
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (in.valid && in.ready) begin
			ir <= in.instr;
		end
	end

	// rs1/rs2 sit at the same place in every format that reads them
	assign rf.ra_addr = ir.r.rs1;
	assign rf.rb_addr = ir.r.rs2;

	//////////////////////////////
	// immediates
	//////////////////////////////
	assign imm_i = {{(`XLEN-12){ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
	assign imm_s = {{(`XLEN-12){ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
	assign imm_b = {{(`XLEN-13){ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11,
		ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
	assign imm_u = {ir.u.imm_31_12, 12'b0};
	assign imm_j = {{(`XLEN-21){ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12,
		ir.j.imm_11, ir.j.imm_10_1, 1'b0};

	always_comb begin
		sub_op = '0;
		sub_op[SUBOP_F3_MSB:SUBOP_F3_LSB] = ir.r.funct3;
		sub_op[SUBOP_ALT_BIT] = ir.r.funct7[5];   // instr[30]
	end

	// operand select by major opcode
	always_comb begin
		nxt_a    = '0;
		nxt_b    = '0;
		nxt_c    = '0;
		nxt_rd   = ir.r.rd;
		nxt_type = OPT_ILLEGAL;
		case (ir.r.opcode)
			OPC_OP: begin
				nxt_type = OPT_ALU_RR;
				nxt_a    = rf.ra_data;
				nxt_b    = rf.rb_data;
				nxt_c    = sub_op;
			end
			OPC_OP_IMM, OPC_LOAD: begin
				nxt_type = (ir.r.opcode == OPC_LOAD) ? OPT_LOAD : OPT_ALU_RI;
				nxt_a    = rf.ra_data;
				nxt_b    = imm_i;
				nxt_c    = sub_op;
			end
			OPC_STORE: begin
				nxt_type = OPT_STORE;
				nxt_a    = rf.ra_data;
				nxt_b    = imm_s;
				nxt_c    = rf.rb_data;   // store data
				nxt_rd   = '0;
			end
			OPC_BRANCH: begin
				nxt_type = OPT_BRANCH;
				nxt_a    = rf.ra_data;
				nxt_b    = rf.rb_data;
				nxt_c    = imm_b;   // branch offset
				nxt_rd   = '0;
			end
			OPC_LUI: begin
				nxt_type = OPT_LUI;
				nxt_b    = imm_u;
			end
			OPC_AUIPC: begin
				nxt_type = OPT_AUIPC;
				nxt_b    = imm_u;   // no pc here
			end
			OPC_JAL: begin
				nxt_type = OPT_JAL;
				nxt_b    = imm_j;
			end
			OPC_JALR: begin
				nxt_type = OPT_JALR;
				nxt_a    = rf.ra_data;
				nxt_b    = imm_i;
			end
			default: begin
				nxt_rd = '0;   // illegal, all zero
			end
		endcase
	end

	// result register, loaded when read data is back
	always_ff @(posedge clock) begin
		if (state == S_DATA) begin
			out.op_a    <= nxt_a;
			out.op_b    <= nxt_b;
			out.op_c    <= nxt_c;
			out.rd      <= nxt_rd;
			out.op_type <= nxt_type;
		end
	end

endmodule

//--- src/reg_file.sv
// module reg_file: 32-entry register file, one write port, two registered read ports per lane
`timescale 1ns/1ns
`include "decode_settings.svh"

module reg_file (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               wr_en,
	input  logic [`REG_AW-1:0] wr_addr,
	input  logic [`XLEN-1:0]   wr_data,
	rf_read_if.regfile         rd [`NUM_LANES]
);

	localparam int NREGS = 2 ** `REG_AW;

	logic [`XLEN-1:0] regs [NREGS];

	//////////////////////////////
	// write port
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;   // x0 stays zero
		end
	end

	//////////////////////////////
	// read ports
	//////////////////////////////
	// data registered, one clock behind the address
	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_port
		always_ff @(posedge clock) begin
			rd[g].ra_data <= regs[rd[g].ra_addr];
			rd[g].rb_data <= regs[rd[g].rb_addr];
		end
	end

endmodule

//--- src/op_collector.sv
// module op_collector: in-order round-robin drain of lane results to the decode output
`timescale 1ns/1ns
`include "decode_settings.svh"

module op_collector import decode_pkg::*; (
	input  logic               clock,
	input  logic               rst_n,
	lane_out_if.collector      lanes [`NUM_LANES],
	output logic               decode_valid,
	input  logic               exec_ready,
	output logic [`XLEN-1:0]   op_a,
	output logic [`XLEN-1:0]   op_b,
	output logic [`XLEN-1:0]   op_c,
	output logic [`REG_AW-1:0] rd_addr,
	output logic [OPT_W-1:0]   op_type
);

	localparam int PW = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;
	localparam logic [PW-1:0] LAST = PW'(`NUM_LANES - 1);

	logic [PW-1:0]         turn;   // lane holding the oldest result
	logic [`NUM_LANES-1:0] lane_valid;
	logic [`XLEN-1:0]      lane_a    [`NUM_LANES];
	logic [`XLEN-1:0]      lane_b    [`NUM_LANES];
	logic [`XLEN-1:0]      lane_c    [`NUM_LANES];
	logic [`REG_AW-1:0]    lane_rd   [`NUM_LANES];
	logic [OPT_W-1:0]      lane_type [`NUM_LANES];

	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
		localparam logic [PW-1:0] IDX = PW'(g);

		assign lane_valid[g] = lanes[g].valid;
		assign lane_a[g]     = lanes[g].op_a;
		assign lane_b[g]     = lanes[g].op_b;
		assign lane_c[g]     = lanes[g].op_c;
		assign lane_rd[g]    = lanes[g].rd;
		assign lane_type[g]  = lanes[g].op_type;
		assign lanes[g].ready = exec_ready && (turn == IDX);
	end

	// same order as dispatch, so program order holds
	assign decode_valid = lane_valid[turn];
	assign op_a    = lane_a[turn];
	assign op_b    = lane_b[turn];
	assign op_c    = lane_c[turn];
	assign rd_addr = lane_rd[turn];
	assign op_type = lane_type[turn];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			turn <= '0;
		end else if (decode_valid && exec_ready) begin
			turn <= (turn == LAST) ? '0 : turn + 1'b1;
		end
	end

endmodule

//--- src/decode_top.sv
// module decode_top: dispatcher, decode lanes, shared register file and in-order collector
`timescale 1ns/1ns
`include "decode_settings.svh"

module decode_top import decode_pkg::*; (
	input  logic               clock,
	input  logic               rst_n,
	// fetch side
	input  logic               fetch_valid,
	output logic               fetch_ready,
	input  logic [`XLEN-1:0]   instr,
	// register load port
	input  logic               wr_en,
	input  logic [`REG_AW-1:0] wr_addr,
	input  logic [`XLEN-1:0]   wr_data,
	// decoded output
	output logic               decode_valid,
	input  logic               exec_ready,
	output logic [`XLEN-1:0]   op_a,
	output logic [`XLEN-1:0]   op_b,
	output logic [`XLEN-1:0]   op_c,
	output logic [`REG_AW-1:0] rd_addr,
	output logic [OPT_W-1:0]   op_type
);

	lane_in_if  lane_in  [`NUM_LANES] ();
	lane_out_if lane_out [`NUM_LANES] ();
	rf_read_if  rf_rd    [`NUM_LANES] ();

	//////////////////////////////
	// front end
	//////////////////////////////
	instr_dispatch u_dispatch (
		.clock        (clock        ),
		.rst_n        (rst_n        ),
		.fetch_valid  (fetch_valid  ),
		.fetch_ready  (fetch_ready  ),
		.instr        (instr        ),
		.lanes        (lane_in      )
	);

	reg_file u_regs (
		.clock        (clock        ),
		.rst_n        (rst_n        ),
		.wr_en        (wr_en        ),
		.wr_addr      (wr_addr      ),
		.wr_data      (wr_data      ),
		.rd           (rf_rd        )
	);

	//////////////////////////////
	// decode lanes
	//////////////////////////////
	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
		decode_lane u_lane (
			.clock    (clock        ),
			.rst_n    (rst_n        ),
			.in       (lane_in[g]   ),
			.out      (lane_out[g]  ),
			.rf       (rf_rd[g]     )
		);
	end

	// results back in program order
	op_collector u_collect (
		.clock        (clock        ),
		.rst_n        (rst_n        ),
		.lanes        (lane_out     ),
		.decode_valid (decode_valid ),
		.exec_ready   (exec_ready   ),
		.op_a         (op_a         ),
		.op_b         (op_b         ),
		.op_c         (op_c         ),
		.rd_addr      (rd_addr      ),
		.op_type      (op_type      )
	);

endmodule

//--- verif/clock_gen.sv
// module clock_gen: free-running testbench clock and power-on reset
`timescale 1ns/1ns

module clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// low over RESET_CYCLES rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule

//--- verif/decode_properties.sv
// module decode_properties: reset, hold, latency and occupancy assertions for decode_top
`timescale 1ns/1ns
`include "decode_settings.svh"

module decode_properties import decode_pkg::*; (
	input logic               clock,
	input logic               rst_n,
	input logic               fetch_valid,
	input logic               fetch_ready,
	input logic               decode_valid,
	input logic               exec_ready,
	input logic [`XLEN-1:0]   op_a,
	input logic [`XLEN-1:0]   op_b,
	input logic [`XLEN-1:0]   op_c,
	input logic [`REG_AW-1:0] rd_addr,
	input logic [OPT_W-1:0]   op_type
);

	int   fails = 0;   // bumped by each failing assertion
	int   inflight;    // accepted, not yet delivered
	logic seen_full;
	logic fetch_xfer;
	logic out_xfer;

	assign fetch_xfer = fetch_valid && fetch_ready;
	assign out_xfer   = decode_valid && exec_ready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			inflight  <= 0;
			seen_full <= 1'b0;
		end else begin
			inflight <= inflight + int'(fetch_xfer) - int'(out_xfer);
			if (inflight == `NUM_LANES) begin
				seen_full <= 1'b1;   // every lane busy at once
			end
		end
	end

	//////////////////////////////
	// protocol
	//////////////////////////////
	a_reset: assert property (@(posedge clock) $rose(rst_n) |-> !decode_valid && fetch_ready)
		else begin
			fails++;
			$error("output valid or fetch stall in the first cycle after reset");
		end

	// stalled result must not move
	a_hold: assert property (@(posedge clock) disable iff (!rst_n)
		decode_valid && !exec_ready |=> decode_valid && $stable(op_a) && $stable(op_b)
		&& $stable(op_c) && $stable(rd_addr) && $stable(op_type))
		else begin
			fails++;
			$error("decode output changed while exec_ready was low");
		end

	// empty pipe, so the new word is the next one out
	a_latency: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_xfer && inflight == 0 |=> !decode_valid [*2])
		else begin
			fails++;
			$error("decode_valid rose less than 2 cycles after fetch");
		end

	a_orphan: assert property (@(posedge clock) disable iff (!rst_n)
		decode_valid |-> inflight != 0)
		else begin
			fails++;
			$error("decode_valid high with nothing in flight");
		end

	a_bound: assert property (@(posedge clock) disable iff (!rst_n) inflight <= `NUM_LANES)
		else begin
			fails++;
			$error("more instructions in flight than lanes");
		end

	c_full: cover property (@(posedge clock) disable iff (!rst_n) inflight == `NUM_LANES);

endmodule

//--- verif/decode_tb.sv
// module decode_tb: stimulus, reference decode, scoreboard and watchdog for decode_top
`timescale 1ns/1ns
`include "decode_settings.svh"

module decode_tb import rv_isa_pkg::*, decode_pkg::*; ();

	localparam int N_X0     = 12;
	localparam int N_BP     = 150;
	localparam int N_STREAM = 100;
	localparam int N_TOTAL  = N_X0 + N_BP + N_STREAM;
	localparam int PERIOD   = 100;
	localparam longint LIMIT_NS =
		(longint'(N_TOTAL) * 200 + 2 * (2 ** `REG_AW) + 10) * PERIOD;
	// expected result packed as {op_type, rd, op_a, op_b, op_c}
	localparam int EXP_W  = 3 * `XLEN + `REG_AW + OPT_W;
	localparam int B_LSB  = `XLEN;
	localparam int A_LSB  = 2 * `XLEN;
	localparam int RD_LSB = 3 * `XLEN;
	localparam int T_LSB  = 3 * `XLEN + `REG_AW;

	logic               clock;
	logic               rst_n;
	logic               fetch_valid;
	logic               fetch_ready;
	logic [`XLEN-1:0]   instr;
	logic               wr_en;
	logic [`REG_AW-1:0] wr_addr;
	logic [`XLEN-1:0]   wr_data;
	logic               decode_valid;
	logic               exec_ready;
	logic [`XLEN-1:0]   op_a;
	logic [`XLEN-1:0]   op_b;
	logic [`XLEN-1:0]   op_c;
	logic [`REG_AW-1:0] rd_addr;
	logic [OPT_W-1:0]   op_type;

	integer           seed = 32'h7e05f599;
	string            test_name = "reset";
	logic [`XLEN-1:0] regs_copy [2 ** `REG_AW];   // model of the register file
	logic [EXP_W-1:0] exp_q [$];

	clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(3)) u_clk (.clock(clock), .rst_n(rst_n));

	decode_top uut (.*);

	bind decode_top decode_properties u_props (
		.clock(clock), .rst_n(rst_n), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
		.decode_valid(decode_valid), .exec_ready(exec_ready), .op_a(op_a), .op_b(op_b),
		.op_c(op_c), .rd_addr(rd_addr), .op_type(op_type)
	);

	task automatic value_error(input string field, input logic [`XLEN-1:0] expv,
		input logic [`XLEN-1:0] actv);
		$display("Error %s: %s expected %h actual %h", test_name, field, expv, actv);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic plain_error(input string msg);
		$display("Error %s: %s", test_name, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	function automatic logic [6:0] pick_opcode(input int k);
		case (k)
			0:       return OPC_OP;
			1:       return OPC_OP_IMM;
			2:       return OPC_LOAD;
			3:       return OPC_STORE;
			4:       return OPC_BRANCH;
			5:       return OPC_LUI;
			6:       return OPC_AUIPC;
			7:       return OPC_JAL;
			8:       return OPC_JALR;
			9:       return 7'b1110011;   // unsupported system opcode
			10:      return 7'b0001111;   // fence
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] make_instr(input bit zero_src);
		logic [`XLEN-1:0] w;
		w = $random(seed);
		w[6:0] = pick_opcode({$random(seed)} % 12);
		if (zero_src) begin
			w[19:15] = '0;
			w[24:20] = '0;
		end
		return w;
	endfunction

	//////////////////////////////
	// reference decode
	//////////////////////////////
	function automatic logic [EXP_W-1:0] ref_decode(input logic [`XLEN-1:0] w);
		logic [`XLEN-1:0]   s1;
		logic [`XLEN-1:0]   s2;
		logic [`XLEN-1:0]   imm_i;
		logic [`XLEN-1:0]   imm_s;
		logic [`XLEN-1:0]   imm_b;
		logic [`XLEN-1:0]   imm_u;
		logic [`XLEN-1:0]   imm_j;
		logic [`XLEN-1:0]   sub;
		logic [`XLEN-1:0]   nul;
		logic [`REG_AW-1:0] rd;
		s1    = regs_copy[w[19:15]];
		s2    = regs_copy[w[24:20]];
		imm_i = {{(`XLEN-12){w[31]}}, w[31:20]};
		imm_s = {{(`XLEN-12){w[31]}}, w[31:25], w[11:7]};
		imm_b = {{(`XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'b0};
		imm_j = {{(`XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		sub   = {{(`XLEN-4){1'b0}}, w[30], w[14:12]};
		nul   = '0;
		rd    = w[11:7];
		case (w[6:0])
			OPC_OP:     return {OPT_ALU_RR, rd, s1, s2, sub};
			OPC_OP_IMM: return {OPT_ALU_RI, rd, s1, imm_i, sub};
			OPC_LOAD:   return {OPT_LOAD, rd, s1, imm_i, sub};
			OPC_STORE:  return {OPT_STORE, {`REG_AW{1'b0}}, s1, imm_s, s2};
			OPC_BRANCH: return {OPT_BRANCH, {`REG_AW{1'b0}}, s1, s2, imm_b};
			OPC_LUI:    return {OPT_LUI, rd, nul, imm_u, nul};
			OPC_AUIPC:  return {OPT_AUIPC, rd, nul, imm_u, nul};
			OPC_JAL:    return {OPT_JAL, rd, nul, imm_j, nul};
			OPC_JALR:   return {OPT_JALR, rd, s1, imm_i, nul};
			default:    return {OPT_ILLEGAL, {`REG_AW{1'b0}}, nul, nul, nul};
		endcase
	endfunction

	task automatic load_regs();
		test_name = "register load";
		for (int r = 0; r < 2 ** `REG_AW; r++) begin
			@(negedge clock);
			wr_en   = 1'b1;
			wr_addr = r[`REG_AW-1:0];
			wr_data = $random(seed);
			regs_copy[r] = (r == 0) ? '0 : wr_data;   // x0 write is dropped
		end
		@(negedge clock);
		wr_en = 1'b0;
	endtask

	task automatic run_phase(input string name, input int count, input bit zero_src,
		input bit stall, input bit gaps);
		int sent;
		bit free;
		sent = 0;
		free = 1'b1;
		test_name = name;
		while (sent < count) begin
			@(negedge clock);
			exec_ready = stall ? ({$random(seed)} % 3 != 0) : 1'b1;
			if (free) begin
				fetch_valid = !(gaps && ({$random(seed)} % 4 == 0));
				instr = make_instr(zero_src);
			end
			@(posedge clock);
			free = !fetch_valid || fetch_ready;
			if (fetch_valid && fetch_ready) begin
				exp_q.push_back(ref_decode(instr));
				sent++;
			end
		end
		@(negedge clock);
		fetch_valid = 1'b0;
	endtask

	//////////////////////////////
	// scoreboard
	//////////////////////////////
	always @(posedge clock) begin : check_out
		logic [EXP_W-1:0] e;
		if (rst_n && decode_valid && exec_ready) begin
			assert (exp_q.size() != 0) else plain_error("result with nothing in flight");
			e = exp_q.pop_front();
			assert (op_type == e[T_LSB +: OPT_W])
				else value_error("op_type", e[T_LSB +: OPT_W], op_type);
			assert (rd_addr == e[RD_LSB +: `REG_AW])
				else value_error("rd", e[RD_LSB +: `REG_AW], rd_addr);
			assert (op_a == e[A_LSB +: `XLEN])
				else value_error("op_a", e[A_LSB +: `XLEN], op_a);
			assert (op_b == e[B_LSB +: `XLEN])
				else value_error("op_b", e[B_LSB +: `XLEN], op_b);
			assert (op_c == e[0 +: `XLEN])
				else value_error("op_c", e[0 +: `XLEN], op_c);
		end
	end

	always @(negedge clock) begin
		assert (uut.u_props.fails == 0) else plain_error("a protocol assertion failed");
	end

	initial begin
		#(LIMIT_NS);
		$display("Timeout in %s: decode results stopped arriving", test_name);
		$display("TEST FAIL");
		$fatal(1);
	end

	initial begin
		fetch_valid = 1'b0;
		instr       = '0;
		wr_en       = 1'b0;
		wr_addr     = '0;
		wr_data     = '0;
		exec_ready  = 1'b0;
		wait (rst_n === 1'b1);
		load_regs();
		run_phase("x0 sources", N_X0, 1'b1, 1'b0, 1'b1);
		run_phase("back-pressure", N_BP, 1'b0, 1'b1, 1'b1);
		run_phase("in-order stream", N_STREAM, 1'b0, 1'b0, 1'b0);
		test_name = "drain";
		@(negedge clock);
		exec_ready = 1'b1;
		while (exp_q.size() != 0) @(negedge clock);
		repeat (4) @(negedge clock);
		if (uut.u_props.seen_full && uut.u_props.fails == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("Error drain: all lanes busy seen %0b, protocol failures %0d",
				uut.u_props.seen_full, uut.u_props.fails);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

endmodule

//--- filelist.f
+incdir+src
src/rv_isa_pkg.sv
src/decode_pkg.sv
src/decode_lane_if.sv
src/instr_dispatch.sv
src/decode_lane.sv
src/reg_file.sv
src/op_collector.sv
src/decode_top.sv
verif/clock_gen.sv
verif/decode_properties.sv
verif/decode_tb.sv
